//--- hdl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address width
`define CPU_WORD 32

// Architectural registers, r0 reads as zero
`define CPU_REGS 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- hdl/cpuTypesPkg.sv
package cpuTypesPkg;

    // ************************************************************
    // Instruction encodings
    // ************************************************************
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        ADDIU = 6'h09,
        SLTI  = 6'h0a,
        SLTIU = 6'h0b,
        ANDI  = 6'h0c,
        ORI   = 6'h0d,
        XORI  = 6'h0e,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcodeT;

    typedef enum logic [5:0] {
        SLLV = 6'h04,
        SRLV = 6'h06,
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } funcT;

    // ************************************************************
    // Datapath selects
    // ************************************************************
    typedef enum logic [3:0] {
        ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
    } aluOpT;

    typedef enum logic [1:0] {JMP_NONE, JMP_TARGET, JMP_REG} jumpSelT;

    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_MEM, WB_UPPER} wbSelT;

    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extSelT;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
    input  logic [`CPU_WORD-1:0] a,
    input  logic [`CPU_WORD-1:0] b,
    input  cpuTypesPkg::aluOpT   op,
    output logic [`CPU_WORD-1:0] result,
    output logic                 zero
);

    always_comb begin
        case (op)
            cpuTypesPkg::ALU_SLL:  result = b << a[4:0];   // Amount from rs
            cpuTypesPkg::ALU_SRL:  result = b >> a[4:0];
            cpuTypesPkg::ALU_ADD:  result = a + b;
            cpuTypesPkg::ALU_SUB:  result = a - b;
            cpuTypesPkg::ALU_AND:  result = a & b;
            cpuTypesPkg::ALU_OR:   result = a | b;
            cpuTypesPkg::ALU_XOR:  result = a ^ b;
            cpuTypesPkg::ALU_NOR:  result = ~(a | b);
            cpuTypesPkg::ALU_SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            cpuTypesPkg::ALU_SLTU: begin
                result = '0;
                result[0] = a < b;
            end
            default: result = a + b;
        endcase
    end

    // Branch compare flag
    assign zero = (result == '0);

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module registerFile (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic [4:0]           rsAddr,
    input  logic [4:0]           rtAddr,
    input  logic [4:0]           wAddr,
    input  logic [`CPU_WORD-1:0] wData,
    input  logic                 wEn,
    output logic [`CPU_WORD-1:0] rsData,
    output logic [`CPU_WORD-1:0] rtData
);

    logic [`CPU_WORD-1:0] regs [`CPU_REGS];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && wAddr != 5'd0) begin   // r0 stays zero
            regs[wAddr] <= wData;
        end
    end

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  cpuTypesPkg::opcodeT  opcode,
    input  cpuTypesPkg::funcT    func,
    output cpuTypesPkg::aluOpT   aluOp,
    output logic                 aluSrc,
    output logic                 regDst,
    output logic                 regWen,
    output cpuTypesPkg::wbSelT   memToReg,
    output cpuTypesPkg::extSelT  extOp,
    output cpuTypesPkg::jumpSelT jumpSel,
    output logic                 jal,
    output logic                 beq,
    output logic                 bne,
    output logic                 dRen,
    output logic                 dWen,
    output logic                 halt
);

    always_comb begin
        aluOp    = cpuTypesPkg::ALU_ADD;
        aluSrc   = 1'b0;   // rt as operand b
        regDst   = 1'b0;
        regWen   = 1'b0;
        memToReg = cpuTypesPkg::WB_ALU;
        extOp    = cpuTypesPkg::EXT_SIGN;
        jumpSel  = cpuTypesPkg::JMP_NONE;
        jal      = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        dRen     = 1'b0;
        dWen     = 1'b0;
        halt     = 1'b0;

        case (opcode)
            cpuTypesPkg::RTYPE: begin
                regDst = 1'b1;
                regWen = 1'b1;
                case (func)
                    cpuTypesPkg::ADD, cpuTypesPkg::ADDU: aluOp = cpuTypesPkg::ALU_ADD;
                    cpuTypesPkg::SUB, cpuTypesPkg::SUBU: aluOp = cpuTypesPkg::ALU_SUB;
                    cpuTypesPkg::AND:  aluOp = cpuTypesPkg::ALU_AND;
                    cpuTypesPkg::OR:   aluOp = cpuTypesPkg::ALU_OR;
                    cpuTypesPkg::XOR:  aluOp = cpuTypesPkg::ALU_XOR;
                    cpuTypesPkg::NOR:  aluOp = cpuTypesPkg::ALU_NOR;
                    cpuTypesPkg::SLT:  aluOp = cpuTypesPkg::ALU_SLT;
                    cpuTypesPkg::SLTU: aluOp = cpuTypesPkg::ALU_SLTU;
                    cpuTypesPkg::SLLV: aluOp = cpuTypesPkg::ALU_SLL;
                    cpuTypesPkg::SRLV: aluOp = cpuTypesPkg::ALU_SRL;
                    cpuTypesPkg::JR: begin
                        regWen  = 1'b0;
                        jumpSel = cpuTypesPkg::JMP_REG;
                    end
                    default: regWen = 1'b0;   // Unknown function
                endcase
            end

            // Immediate arithmetic and logic
            cpuTypesPkg::ADDI, cpuTypesPkg::ADDIU: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
            end
            cpuTypesPkg::SLTI: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
                aluOp  = cpuTypesPkg::ALU_SLT;
            end
            cpuTypesPkg::SLTIU: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
                aluOp  = cpuTypesPkg::ALU_SLTU;
            end
            cpuTypesPkg::ANDI: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
                aluOp  = cpuTypesPkg::ALU_AND;
                extOp  = cpuTypesPkg::EXT_ZERO;
            end
            cpuTypesPkg::ORI: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
                aluOp  = cpuTypesPkg::ALU_OR;
                extOp  = cpuTypesPkg::EXT_ZERO;
            end
            cpuTypesPkg::XORI: begin
                regWen = 1'b1;
                aluSrc = 1'b1;
                aluOp  = cpuTypesPkg::ALU_XOR;
                extOp  = cpuTypesPkg::EXT_ZERO;
            end
            cpuTypesPkg::LUI: begin
                regWen   = 1'b1;
                aluSrc   = 1'b1;
                extOp    = cpuTypesPkg::EXT_UPPER;
                memToReg = cpuTypesPkg::WB_UPPER;
            end

            // Branches compare through the subtractor
            cpuTypesPkg::BEQ: begin
                aluOp = cpuTypesPkg::ALU_SUB;
                beq   = 1'b1;
            end
            cpuTypesPkg::BNE: begin
                aluOp = cpuTypesPkg::ALU_SUB;
                bne   = 1'b1;
            end

            cpuTypesPkg::LW: begin
                regWen   = 1'b1;
                aluSrc   = 1'b1;
                dRen     = 1'b1;
                memToReg = cpuTypesPkg::WB_MEM;
            end
            cpuTypesPkg::SW: begin
                aluSrc = 1'b1;
                dWen   = 1'b1;
            end

            cpuTypesPkg::J: jumpSel = cpuTypesPkg::JMP_TARGET;
            cpuTypesPkg::JAL: begin
                regWen   = 1'b1;
                jal      = 1'b1;   // Link into r31
                jumpSel  = cpuTypesPkg::JMP_TARGET;
                memToReg = cpuTypesPkg::WB_LINK;
            end

            cpuTypesPkg::HALT: halt = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- hdl/dataBusMaster.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataBusMaster (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   memReq,
    input  logic                   memWrite,
    input  logic [`CPU_WORD-1:0]   memAddr,
    input  logic [`CPU_WORD-1:0]   memWData,
    output logic                   memDone,
    output logic [`CPU_WORD-1:0]   memRData,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [`CPU_WORD-1:0]   adr,
    output logic [`CPU_WORD-1:0]   datOut,
    output logic [`CPU_WORD/8-1:0] sel,
    input  logic [`CPU_WORD-1:0]   datIn,
    input  logic                   ack
);

    typedef enum logic {IDLE, BUSY} stateT;

    stateT state;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
            we    <= 1'b0;
        end else begin
            case (state)
                IDLE: if (memReq) begin
                    state <= BUSY;
                    we    <= memWrite;
                end
                BUSY: if (ack) begin
                    state <= IDLE;   // One idle cycle before the next request
                    we    <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and store data held for the whole cycle
    always_ff @(posedge CLK) begin
        if (state == IDLE && memReq) begin
            adr    <= memAddr;
            datOut <= memWData;
        end
    end

    assign cyc      = (state == BUSY);
    assign stb      = cyc;
    assign sel      = '1;   // Word accesses only
    assign memDone  = cyc && ack;
    assign memRData = datIn;

endmodule

//--- hdl/mipsCore.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mipsCore (
    input  logic                   CLK,
    input  logic                   rst,
    output logic [`CPU_WORD-1:0]   iAddr,
    input  logic [`CPU_WORD-1:0]   iData,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [`CPU_WORD-1:0]   adr,
    output logic [`CPU_WORD-1:0]   datOut,
    output logic [`CPU_WORD/8-1:0] sel,
    input  logic [`CPU_WORD-1:0]   datIn,
    input  logic                   ack,
    output logic                   halted
);

    logic [`CPU_WORD-1:0] pc, pcPlus4, nextPc, branchTarget, jumpTarget;
    logic [`CPU_WORD-1:0] extImm, upperImm, aluB, aluResult, wbData;
    logic [`CPU_WORD-1:0] rsData, rtData, memRData;
    logic [4:0]           wAddr;
    logic [15:0]          imm;
    logic                 aluSrc, regDst, regWen, jal, beq, bne, dRen, dWen, halt;
    logic                 zero, isMem, memReq, memDone, retire, branchTaken;
    cpuTypesPkg::aluOpT   aluOp;
    cpuTypesPkg::wbSelT   memToReg;
    cpuTypesPkg::extSelT  extOp;
    cpuTypesPkg::jumpSelT jumpSel;

    assign imm = iData[15:0];

    controlUnit ctrl0 (
        .opcode(cpuTypesPkg::opcodeT'(iData[31:26])),
        .func(cpuTypesPkg::funcT'(iData[5:0])),
        .aluOp(aluOp), .aluSrc(aluSrc), .regDst(regDst), .regWen(regWen),
        .memToReg(memToReg), .extOp(extOp), .jumpSel(jumpSel), .jal(jal),
        .beq(beq), .bne(bne), .dRen(dRen), .dWen(dWen), .halt(halt)
    );

    // ************************************************************
    // Operand selection and execute
    // ************************************************************
    assign wAddr    = jal ? 5'(`CPU_REGS - 1) : (regDst ? iData[15:11] : iData[20:16]);
    assign upperImm = {imm, 16'h0000};

    always_comb begin
        case (extOp)
            cpuTypesPkg::EXT_ZERO:  extImm = {16'h0000, imm};
            cpuTypesPkg::EXT_UPPER: extImm = upperImm;
            default:                extImm = {{16{imm[15]}}, imm};
        endcase
    end

    assign aluB = aluSrc ? extImm : rtData;

    registerFile regs0 (
        .CLK(CLK), .rst(rst), .rsAddr(iData[25:21]), .rtAddr(iData[20:16]),
        .wAddr(wAddr), .wData(wbData), .wEn(regWen && retire),
        .rsData(rsData), .rtData(rtData)
    );

    alu alu0 (.a(rsData), .b(aluB), .op(aluOp), .result(aluResult), .zero(zero));

    assign isMem  = dRen || dWen;
    assign memReq = isMem && !halted;

    dataBusMaster dbm0 (
        .CLK(CLK), .rst(rst), .memReq(memReq), .memWrite(dWen),
        .memAddr(aluResult), .memWData(rtData), .memDone(memDone), .memRData(memRData),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datOut(datOut), .sel(sel),
        .datIn(datIn), .ack(ack)
    );

    // ************************************************************
    // Next PC and write-back
    // ************************************************************
    assign pcPlus4      = pc + `CPU_WORD'(4);
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], iData[25:0], 2'b00};
    assign branchTaken  = (beq && zero) || (bne && !zero);

    always_comb begin
        case (jumpSel)
            cpuTypesPkg::JMP_TARGET: nextPc = jumpTarget;
            cpuTypesPkg::JMP_REG:    nextPc = rsData;
            default:                 nextPc = branchTaken ? branchTarget : pcPlus4;
        endcase
    end

    always_comb begin
        case (memToReg)
            cpuTypesPkg::WB_LINK:  wbData = pcPlus4;
            cpuTypesPkg::WB_MEM:   wbData = memRData;
            cpuTypesPkg::WB_UPPER: wbData = upperImm;
            default:               wbData = aluResult;
        endcase
    end

    // Memory instructions wait for the bus ack
    assign retire = !halted && !halt && (!isMem || memDone);

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc     <= `CPU_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (retire) pc <= nextPc;
            if (halt) halted <= 1'b1;   // Sticky until reset
        end
    end

    assign iAddr = pc;

endmodule

//--- test/mipsModel.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// Expected bus traffic and PC trace
logic [31:0] expStAddr [$];
logic [31:0] expStData [$];
logic [31:0] expLdAddr [$];
logic [31:0] pcTrace [$];
logic [31:0] mRegs [32];
logic [31:0] mMem [256];

task automatic runModel();
    logic [31:0] pc, nextPc, ins, a, b, sImm, zImm, res;
    logic [4:0]  dst;
    logic        wr, done;
    int          steps;
    pc    = `CPU_RESET_PC;
    done  = 1'b0;
    steps = 0;
    for (int r = 0; r < 32; r++) begin
        mRegs[r] = '0;
    end
    for (int w = 0; w < 256; w++) begin
        mMem[w] = fillWord(w);
    end
    while (!done) begin
        pcTrace.push_back(pc);
        ins    = prog[pc[9:2]];
        a      = mRegs[ins[25:21]];
        b      = mRegs[ins[20:16]];
        sImm   = {{16{ins[15]}}, ins[15:0]};
        zImm   = {16'h0000, ins[15:0]};
        nextPc = pc + 32'd4;
        dst    = ins[20:16];
        wr     = 1'b1;
        res    = '0;
        case (ins[31:26])
            cpuTypesPkg::RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    cpuTypesPkg::ADD, cpuTypesPkg::ADDU: res = a + b;
                    cpuTypesPkg::SUB, cpuTypesPkg::SUBU: res = a - b;
                    cpuTypesPkg::AND:  res = a & b;
                    cpuTypesPkg::OR:   res = a | b;
                    cpuTypesPkg::XOR:  res = a ^ b;
                    cpuTypesPkg::NOR:  res = ~(a | b);
                    cpuTypesPkg::SLT:  res = {31'b0, $signed(a) < $signed(b)};
                    cpuTypesPkg::SLTU: res = {31'b0, a < b};
                    cpuTypesPkg::SLLV: res = b << a[4:0];   // Shift amount from rs
                    cpuTypesPkg::SRLV: res = b >> a[4:0];
                    cpuTypesPkg::JR: begin
                        wr     = 1'b0;
                        nextPc = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            cpuTypesPkg::ADDI, cpuTypesPkg::ADDIU: res = a + sImm;
            cpuTypesPkg::SLTI:  res = {31'b0, $signed(a) < $signed(sImm)};
            cpuTypesPkg::SLTIU: res = {31'b0, a < sImm};
            cpuTypesPkg::ANDI:  res = a & zImm;
            cpuTypesPkg::ORI:   res = a | zImm;
            cpuTypesPkg::XORI:  res = a ^ zImm;
            cpuTypesPkg::LUI:   res = {ins[15:0], 16'h0000};
            cpuTypesPkg::LW: begin
                expLdAddr.push_back(a + sImm);
                res = mMem[(a + sImm) >> 2];
            end
            cpuTypesPkg::SW: begin
                wr  = 1'b0;
                res = a + sImm;
                expStAddr.push_back(res);
                expStData.push_back(b);
                mMem[res[9:2]] = b;
            end
            cpuTypesPkg::BEQ: begin
                wr = 1'b0;
                if (a == b) nextPc = nextPc + (sImm << 2);
            end
            cpuTypesPkg::BNE: begin
                wr = 1'b0;
                if (a != b) nextPc = nextPc + (sImm << 2);
            end
            cpuTypesPkg::J: begin
                wr     = 1'b0;
                nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            end
            cpuTypesPkg::JAL: begin
                dst    = 5'd31;
                res    = nextPc;   // Link value
                nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            end
            cpuTypesPkg::HALT: begin
                wr     = 1'b0;
                done   = 1'b1;
                nextPc = pc;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) mRegs[dst] = res;
        pc = nextPc;
        steps++;
        assert (steps <= PROG_LEN) else reportProblem("reference model ran past the program");
    end
endtask

`endif

//--- test/mipsCoreTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mipsCoreTb;

    localparam int PROG_LEN = 200;
    localparam int BODY_END = PROG_LEN - 32;   // Final stores and HALT follow
    localparam int TIMEOUT  = PROG_LEN * 6 + 100;
    localparam logic [31:0] HALT_WORD = {6'h3f, 26'h0};

    logic        CLK, rst, ack, cyc, stb, we, halted;
    logic [31:0] iAddr, iData, adr, datOut, datIn;
    logic [3:0]  sel;

    logic [31:0] prog [256];
    logic [31:0] dMem [256];
    logic        isJr [256];
    logic [31:0] lfsr, lastAddr, snapAdr, snapDat;
    logic        snapWe, busy, inReset, haltSeen;
    int          waitLeft, traceIdx, cycles;

    mipsCore dut0 (
        .CLK(CLK), .rst(rst), .iAddr(iAddr), .iData(iData),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datOut(datOut), .sel(sel),
        .datIn(datIn), .ack(ack), .halted(halted)
    );

    // Combinational instruction memory
    assign iData = (iAddr < 32'd1024) ? prog[iAddr[9:2]] : HALT_WORD;

    always #10 CLK = ~CLK;

    // ************************************************************
    // Failure reporting and random numbers
    // ************************************************************
    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic reportProblem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stopRun();
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrStep(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] fillWord(input int w);
        logic [7:0] a;
        a = 8'(w);
        return {~a, a, a ^ 8'ha5, 8'h3c};
    endfunction

    // ************************************************************
    // Program generation
    // ************************************************************
    function automatic logic [31:0] encR(input logic [5:0] func, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'h00, func};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pickFunc(input logic [3:0] k);
        case (k)
            4'd0:        return cpuTypesPkg::ADD;
            4'd1:        return cpuTypesPkg::ADDU;
            4'd2:        return cpuTypesPkg::SUB;
            4'd3:        return cpuTypesPkg::SUBU;
            4'd4:        return cpuTypesPkg::AND;
            4'd5:        return cpuTypesPkg::OR;
            4'd6:        return cpuTypesPkg::XOR;
            4'd7:        return cpuTypesPkg::NOR;
            4'd8, 4'd12: return cpuTypesPkg::SLT;
            4'd9, 4'd13: return cpuTypesPkg::SLTU;
            4'd10, 4'd14: return cpuTypesPkg::SLLV;
            default:     return cpuTypesPkg::SRLV;
        endcase
    endfunction

    function automatic logic [5:0] pickImmOp(input logic [2:0] k);
        case (k)
            3'd0:    return cpuTypesPkg::ADDI;
            3'd1:    return cpuTypesPkg::ADDIU;
            3'd2:    return cpuTypesPkg::SLTI;
            3'd3:    return cpuTypesPkg::SLTIU;
            3'd4:    return cpuTypesPkg::ANDI;
            3'd5:    return cpuTypesPkg::ORI;
            3'd6:    return cpuTypesPkg::XORI;
            default: return cpuTypesPkg::LUI;
        endcase
    endfunction

    // Forward only and never straight onto a JR past its ORI
    function automatic int forwardTarget(input int i);
        int t;
        t = i + 1 + int'(randBits(4));
        if (t > BODY_END) t = BODY_END;
        if (isJr[t]) t = t - 1;
        return t;
    endfunction

    // Built from the end backwards so that targets already exist
    task automatic buildProgram();
        int         i, t;
        logic [3:0] kind;
        logic [4:0] rs, rt, rd;
        logic [15:0] imm;
        logic [5:0] op;
        for (int k = 0; k < 256; k++) begin
            prog[k] = HALT_WORD;
            isJr[k] = 1'b0;
        end
        i = BODY_END - 1;
        while (i >= 1) begin
            kind = 4'(randBits(4));
            rs   = 5'(randBits(5));
            rt   = 5'(randBits(5));
            rd   = 5'(randBits(5));
            imm  = 16'(randBits(16));
            if (kind == 4'd15 && i >= 2) begin
                t = forwardTarget(i);
                prog[i]     = encR(cpuTypesPkg::JR, 5'd30, 5'd0, 5'd0);
                prog[i - 1] = encI(cpuTypesPkg::ORI, 5'd0, 5'd30, 16'(t * 4));
                isJr[i]     = 1'b1;
                i = i - 2;
            end else begin
                case (kind)
                    4'd6, 4'd7, 4'd8, 4'd9: prog[i] = encI(pickImmOp(3'(randBits(3))), rs, rt, imm);
                    4'd10: prog[i] = encI(cpuTypesPkg::LW, 5'd0, rt, {imm[7:0], 2'b00} & 16'h03fc);
                    4'd11: prog[i] = encI(cpuTypesPkg::SW, 5'd0, rt, {imm[7:0], 2'b00} & 16'h03fc);
                    4'd12, 4'd13: begin
                        t  = forwardTarget(i);
                        op = (kind == 4'd12) ? cpuTypesPkg::BEQ : cpuTypesPkg::BNE;
                        prog[i] = encI(op, rs, rt, 16'(t - i - 1));
                    end
                    4'd14: begin
                        t  = forwardTarget(i);
                        op = randBits(1) ? cpuTypesPkg::JAL : cpuTypesPkg::J;
                        prog[i] = {op, 26'(t)};
                    end
                    default: prog[i] = encR(pickFunc(4'(randBits(4))), rs, rt, rd);
                endcase
                i = i - 1;
            end
        end
        prog[0] = encI(cpuTypesPkg::SW, 5'd0, 5'd5, 16'h0000);   // r5 straight out of reset
        for (int k = 1; k < 32; k++) begin
            prog[BODY_END + k - 1] = encI(cpuTypesPkg::SW, 5'd0, 5'(k), 16'(k * 4));
        end
        prog[PROG_LEN - 1] = HALT_WORD;
    endtask

    `include "mipsModel.svh"

    // ************************************************************
    // Wishbone slave and checks
    // ************************************************************
    task automatic expectAccess();
        if (we) begin
            assert (expStAddr.size() > 0) else reportProblem("store that the model does not make");
            checkValue("adr", expStAddr.pop_front(), adr);
            checkValue("datOut", expStData.pop_front(), datOut);
        end else begin
            assert (expLdAddr.size() > 0) else reportProblem("load that the model does not make");
            checkValue("adr", expLdAddr.pop_front(), adr);
        end
    endtask

    always @(posedge CLK) begin
        inReset <= rst;
        cycles++;
        assert (cycles <= TIMEOUT) else reportProblem("timeout, core never finished the program");
    end

    always @(negedge CLK) begin
        if (!inReset) begin
            if (iAddr !== lastAddr) begin   // One retire per PC change
                assert (traceIdx < pcTrace.size()) else reportProblem("PC moved past the program");
                checkValue("iAddr", pcTrace[traceIdx], iAddr);
                traceIdx++;
                lastAddr = iAddr;
            end
            if (halted) haltSeen = 1'b1;
            assert (!haltSeen || halted) else reportProblem("halted dropped without a reset");
            assert (!halted || !cyc) else reportProblem("bus cycle started after HALT");

            if (ack) begin
                ack = 1'b0;
                assert (!cyc) else reportProblem("cyc still high the cycle after ack");
            end else if (cyc) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = int'(randBits(2));   // 0 to 3 wait states
                    snapAdr  = adr;
                    snapDat  = datOut;
                    snapWe   = we;
                    checkValue("sel", 32'hf, 32'(sel));
                    expectAccess();
                end
                checkValue("stb", 32'd1, 32'(stb));
                checkValue("adr", snapAdr, adr);
                checkValue("we", 32'(snapWe), 32'(we));
                checkValue("datOut", snapDat, datOut);
                if (waitLeft == 0) begin
                    ack  = 1'b1;
                    busy = 1'b0;
                    if (we) dMem[adr[9:2]] = datOut;
                    else datIn = dMem[adr[9:2]];
                end else begin
                    waitLeft--;
                end
            end else begin
                assert (!busy) else reportProblem("cyc dropped before ack");
            end
        end
    end

    initial begin
        CLK      = 1'b0;
        rst      = 1'b1;
        ack      = 1'b0;
        datIn    = '0;
        lfsr     = 32'he1be;
        busy     = 1'b0;
        inReset  = 1'b1;
        haltSeen = 1'b0;
        waitLeft = 0;
        traceIdx = 1;
        cycles   = 0;
        buildProgram();
        for (int w = 0; w < 256; w++) begin
            dMem[w] = fillWord(w);
        end
        runModel();

        repeat (5) @(negedge CLK);
        checkValue("iAddr", `CPU_RESET_PC, iAddr);
        assert (!cyc && !stb && !we && !halted) else
            reportProblem("cyc, stb, we or halted high in reset");
        lastAddr = iAddr;
        rst = 1'b0;

        while (!halted) @(negedge CLK);
        repeat (20) @(negedge CLK);   // Core must stay quiet
        assert (expStAddr.size() == 0) else reportProblem("core made fewer stores than the model");
        assert (expLdAddr.size() == 0) else reportProblem("core made fewer loads than the model");
        checkValue("retired count", 32'(pcTrace.size()), 32'(traceIdx));
        $display("All tests passed");
        $finish;
    end

endmodule

//--- mipsCore.f
+incdir+hdl
+incdir+test
hdl/cpuTypesPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/controlUnit.sv
hdl/dataBusMaster.sv
hdl/mipsCore.sv
test/mipsCoreTb.sv
